//--- verilog/dmem_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory sizes and APB address field layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

`define DMEM_DATA_W   32   // Data word width
`define DMEM_DEPTH    256  // Number of words in the RAM
`define DMEM_WORD_AW  8    // Word address width, log2 of depth

// paddr = {size code, byte address}
`define DMEM_ADDR_W   10   // Byte address field, low bits of paddr
`define DMEM_SIZE_LSB 10   // Lowest bit of the 3-bit width code
`define DMEM_SIZE_W   3    // Width code field, funct3 style
`define DMEM_PADDR_W  13   // Full APB address width

`endif

//--- verilog/dmem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types: access width code, RAM request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

package dmem_pkg;

  // Load/store width, same encoding as a RISC-V funct3
  typedef enum logic [`DMEM_SIZE_W-1:0] {
    size_b  = 3'b000,  // Signed byte
    size_h  = 3'b001,  // Signed halfword
    size_w  = 3'b010,  // Word
    size_bu = 3'b100,  // Unsigned byte
    size_hu = 3'b101   // Unsigned halfword
  } access_size_e;
  // 011, 110, 111 are not legal and get refused as misaligned

  // One RAM access, 47 bits
  typedef struct packed {
    logic                       we;         // Write strobe, single cycle
    logic                       re;         // Read strobe, single cycle
    logic [`DMEM_DATA_W/8-1:0]  be;         // Byte lane enables
    logic [`DMEM_WORD_AW-1:0]   word_addr;  // Word index
    logic [`DMEM_DATA_W-1:0]    wdata;      // Lane-steered store data
    logic                       rsvd;       // Spare, kept at zero
  } ram_req_t;

endpackage

`default_nettype wire

//--- verilog/data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-enabled single-port block RAM
// Synchronous read, optional output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

module data_ram import dmem_pkg::*; #(
  parameter int OUT_REG = 0  // 0 gives 1-cycle read, 1 gives 2-cycle read
) (
  input  logic                    clk,
  input  logic                    rsta,     // Clears output stage only
  input  ram_req_t                ram_req,
  output logic [`DMEM_DATA_W-1:0] rd_word
);

  localparam int LANES = `DMEM_DATA_W / 8;

  // Storage, zero at start of simulation
  logic [`DMEM_DATA_W-1:0] mem [`DMEM_DEPTH] = '{default: '0};
  logic [`DMEM_DATA_W-1:0] ram_q;  // First read stage, inside the BRAM

  // Write port, per-lane enables
  always_ff @(posedge clk) begin
    if (ram_req.we) begin
      for (int i = 0; i < LANES; i++) begin
        if (ram_req.be[i]) begin
          mem[ram_req.word_addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read register, holds its value when re is low
  always_ff @(posedge clk) begin
    if (ram_req.re) begin
      ram_q <= mem[ram_req.word_addr];
    end
  end

  // Second stage for better clock-to-out
  if (OUT_REG != 0) begin : g_out_reg
    logic [`DMEM_DATA_W-1:0] out_q;

    always_ff @(posedge clk) begin
      if (rsta) begin
        out_q <= '0;
      end else begin
        out_q <= ram_q;  // Free running, one cycle behind ram_q
      end
    end

    assign rd_word = out_q;
  end else begin : g_no_out_reg
    assign rd_word = ram_q;  // Straight from the BRAM latch
  end

endmodule

`default_nettype wire

//--- verilog/lsu_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store lane steering, load extract and extend,
// alignment check on the APB address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

module lsu_align import dmem_pkg::*; (
  input  logic [`DMEM_PADDR_W-1:0]   paddr,
  input  logic [`DMEM_DATA_W-1:0]    pwdata,
  input  logic [`DMEM_DATA_W-1:0]    rd_word,    // Raw word from the RAM
  output logic [`DMEM_DATA_W/8-1:0]  be,
  output logic [`DMEM_WORD_AW-1:0]   word_addr,
  output logic [`DMEM_DATA_W-1:0]    st_data,
  output logic [`DMEM_DATA_W-1:0]    load_data,
  output logic                       misaligned
);

  access_size_e            size;
  logic [1:0]              byte_off;   // Byte within the word
  logic [`DMEM_DATA_W-1:0] lane_data;  // Addressed item moved to bit 0

  // Address field split
  assign size      = access_size_e'(paddr[`DMEM_SIZE_LSB +: `DMEM_SIZE_W]);
  assign byte_off  = paddr[1:0];
  assign word_addr = paddr[`DMEM_ADDR_W-1:2];

  assign lane_data = rd_word >> {byte_off, 3'b000};

  // Alignment and legal code check
  always_comb begin
    case (size)
      size_b, size_bu: misaligned = 1'b0;            // Bytes fit anywhere
      size_h, size_hu: misaligned = byte_off[0];     // Even addresses only
      size_w:          misaligned = byte_off != 2'b00;
      default:         misaligned = 1'b1;            // 011, 110, 111
    endcase
  end

  // Store side: replicate data, pick lanes
  always_comb begin
    case (size)
      size_b, size_bu: begin
        be      = 4'b0001 << byte_off;
        st_data = {4{pwdata[7:0]}};
      end
      size_h, size_hu: begin
        be      = byte_off[1] ? 4'b1100 : 4'b0011;
        st_data = {2{pwdata[15:0]}};
      end
      size_w: begin
        be      = 4'b1111;
        st_data = pwdata;
      end
      default: begin
        be      = 4'b0000;  // Never written, slave holds we low
        st_data = pwdata;
      end
    endcase
  end

  // Load side: sign or zero extension
  always_comb begin
    case (size)
      size_b:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      size_bu: load_data = {24'h0, lane_data[7:0]};
      size_h:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      size_hu: load_data = {16'h0, lane_data[15:0]};
      default: load_data = rd_word;  // Word, or error response
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/apb_dmem_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave for the data memory
// Single-cycle RAM strobes, read wait counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

module apb_dmem_slave import dmem_pkg::*; #(
  parameter int OUT_REG = 0  // Must match the RAM instance
) (
  input  logic                       clk,
  input  logic                       rsta,
  // APB control from the master
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  // Decoded access from the aligner
  input  logic [`DMEM_DATA_W/8-1:0]  be,
  input  logic [`DMEM_WORD_AW-1:0]   word_addr,
  input  logic [`DMEM_DATA_W-1:0]    st_data,
  input  logic                       misaligned,
  input  logic [`DMEM_DATA_W-1:0]    load_data,
  // To the RAM
  output ram_req_t                   ram_req,
  // APB response
  output logic [`DMEM_DATA_W-1:0]    prdata,
  output logic                       pready,
  output logic                       pslverr
);

  // Read needs OUT_REG+1 wait states before pready
  localparam logic [1:0] RD_WAITS = 2'(OUT_REG + 1);

  logic       access;     // Access phase, psel and penable both high
  logic       in_acc;     // Access phase already past its first cycle
  logic       first_acc;  // First cycle of the access phase
  logic [1:0] wait_cnt;   // Wait states inserted so far
  logic       rd_done;

  assign access    = psel & penable;
  assign first_acc = access & ~in_acc;
  assign rd_done   = in_acc & ~pwrite & (wait_cnt == RD_WAITS);

  // Writes and errors finish at once, reads wait for the RAM pipe
  assign pready  = (first_acc & (pwrite | misaligned)) | rd_done;
  assign pslverr = first_acc & misaligned;  // Refused, memory untouched
  assign prdata  = load_data;

  // Only one strobe per transfer, in the first access cycle
  always_comb begin
    ram_req.we        = first_acc & pwrite & ~misaligned;
    ram_req.re        = first_acc & ~pwrite & ~misaligned;
    ram_req.be        = be;
    ram_req.word_addr = word_addr;
    ram_req.wdata     = st_data;
    ram_req.rsvd      = 1'b0;
  end

  // Access phase tracking, held until pready closes the transfer
  always_ff @(posedge clk) begin
    if (rsta) begin
      in_acc <= 1'b0;
    end else begin
      in_acc <= access & ~pready;
    end
  end

  // Count wait states, cleared at the end of each transfer
  always_ff @(posedge clk) begin
    if (rsta) begin
      wait_cnt <= '0;
    end else if (access & ~pready) begin
      wait_cnt <= wait_cnt + 2'd1;
    end else begin
      wait_cnt <= '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory top: APB slave, aligner, RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

module dmem_top import dmem_pkg::*; #(
  parameter int OUT_REG = 0  // 1 adds a RAM output register
) (
  input  logic                     clk,
  input  logic                     rsta,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`DMEM_PADDR_W-1:0] paddr,   // {size code, byte address}
  input  logic [`DMEM_DATA_W-1:0]  pwdata,
  output logic [`DMEM_DATA_W-1:0]  prdata,
  output logic                     pready,
  output logic                     pslverr
);

  ram_req_t                  ram_req;
  logic [`DMEM_DATA_W/8-1:0] be;
  logic [`DMEM_WORD_AW-1:0]  word_addr;
  logic [`DMEM_DATA_W-1:0]   st_data;
  logic [`DMEM_DATA_W-1:0]   load_data;
  logic [`DMEM_DATA_W-1:0]   rd_word;
  logic                      misaligned;

  apb_dmem_slave #(
    .OUT_REG (OUT_REG)
  ) i_apb_dmem_slave (
    .clk        (clk),
    .rsta       (rsta),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .be         (be),
    .word_addr  (word_addr),
    .st_data    (st_data),
    .misaligned (misaligned),
    .load_data  (load_data),
    .ram_req    (ram_req),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  // Pure decode of the held APB address and data
  lsu_align i_lsu_align (
    .paddr      (paddr),
    .pwdata     (pwdata),
    .rd_word    (rd_word),
    .be         (be),
    .word_addr  (word_addr),
    .st_data    (st_data),
    .load_data  (load_data),
    .misaligned (misaligned)
  );

  data_ram #(
    .OUT_REG (OUT_REG)
  ) i_data_ram (
    .clk     (clk),
    .rsta    (rsta),
    .ram_req (ram_req),
    .rd_word (rd_word)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock, 10 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 5  // Half period in ns
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;  // First rising edge at 5 ns
  end

  always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

//--- tb/tb_dmem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the APB data memory
// APB driver tasks, reference word model, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dmem_defs.svh"

module tb_dmem import dmem_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int OUT_REG     = 1;
  localparam int ACC_TIMEOUT = 16;  // Access cycles allowed per transfer
  localparam int SAMPLE_DLY  = 2;   // Sample point, ns after the falling edge

  logic                     clk;
  logic                     rsta;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`DMEM_PADDR_W-1:0] paddr;
  logic [`DMEM_DATA_W-1:0]  pwdata;
  logic [`DMEM_DATA_W-1:0]  prdata;
  logic                     pready;
  logic                     pslverr;
  integer                   seed;
  int                       errors;
  int                       checks;
  int                       timeouts;
  logic [`DMEM_DATA_W-1:0]  ref_mem [`DMEM_DEPTH] = '{default: '0};  // Expected contents

  tb_clock i_tb_clock (.clk(clk));

  dmem_top #(.OUT_REG(OUT_REG)) i_dmem_top (
    .clk     (clk),
    .rsta    (rsta),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  function automatic logic [`DMEM_PADDR_W-1:0] make_paddr(logic [2:0] size, logic [9:0] baddr);
    return {size, baddr};  // Width code above the byte address
  endfunction

  // Store into the model, lanes as the width rules say
  function automatic void model_store(logic [2:0] size, logic [9:0] baddr, logic [31:0] data);
    case (size)
      size_b, size_bu: ref_mem[baddr[9:2]][{baddr[1:0], 3'b000} +: 8] = data[7:0];
      size_h, size_hu: ref_mem[baddr[9:2]][{baddr[1], 4'b0000} +: 16] = data[15:0];
      default:         ref_mem[baddr[9:2]] = data;
    endcase
  endfunction

  function automatic logic [31:0] model_load(logic [2:0] size, logic [9:0] baddr);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = ref_mem[baddr[9:2]];
    b    = word[{baddr[1:0], 3'b000} +: 8];
    h    = baddr[1] ? word[31:16] : word[15:0];  // Halfwords sit on even addresses
    case (size)
      size_b:  return {{24{b[7]}}, b};
      size_bu: return {24'h0, b};
      size_h:  return {{16{h[15]}}, h};
      size_hu: return {16'h0, h};
      default: return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Access phase: poll pready once per cycle, then back to idle
  task automatic finish_access(output logic [31:0] rdata, output logic err, output int cycles);
    logic done;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    cycles = 0;
    while (!done && cycles < ACC_TIMEOUT) begin
      #SAMPLE_DLY;
      cycles++;
      if (pready) begin
        rdata = prdata;
        err   = pslverr;
        done  = 1'b1;
      end
      @(negedge clk);
    end
    if (!done) begin
      $display("Timeout at %0t: pready stayed low for %0d access cycles", $time, cycles);
      errors++;
      timeouts++;
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [12:0] addr, input logic [31:0] data,
                           output logic err, output int cycles);
    logic [31:0] unused_rd;
    @(negedge clk);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    finish_access(unused_rd, err, cycles);
  endtask

  task automatic apb_read(input logic [12:0] addr, output logic [31:0] rdata,
                          output logic err, output int cycles);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    finish_access(rdata, err, cycles);
  endtask

  task automatic store(input logic [2:0] size, input logic [9:0] baddr, input logic [31:0] data);
    logic err;
    int   cycles;
    apb_write(make_paddr(size, baddr), data, err, cycles);
    check_value("pslverr", 32'(err), 32'd0);
    model_store(size, baddr, data);
  endtask

  task automatic load_check(input logic [2:0] size, input logic [9:0] baddr,
                            output logic [31:0] rdata);
    logic err;
    int   cycles;
    apb_read(make_paddr(size, baddr), rdata, err, cycles);
    check_value("pslverr", 32'(err), 32'd0);
    check_value("prdata", rdata, model_load(size, baddr));
  endtask

  task automatic load_expect(input logic [2:0] size, input logic [9:0] baddr,
                             input logic [31:0] exp);
    logic [31:0] rdata;
    load_check(size, baddr, rdata);
    check_value("prdata", rdata, exp);  // Literal value from the extension rules
  endtask

  // Refused transfer: one cycle, pslverr high
  task automatic refused(input logic wr, input logic [2:0] size, input logic [9:0] baddr);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    if (wr) begin
      apb_write(make_paddr(size, baddr), 32'h1234_5678, err, cycles);
    end else begin
      apb_read(make_paddr(size, baddr), rdata, err, cycles);
    end
    check_value("pslverr", 32'(err), 32'd1);
    check_value("pready cycles", cycles, 1);
  endtask

  task automatic test_timing();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    #SAMPLE_DLY;
    check_value("pready", 32'(pready), 32'd0);  // Idle after reset
    apb_write(make_paddr(size_w, {8'd140, 2'd0}), 32'h0bad_cafe, err, cycles);
    model_store(size_w, {8'd140, 2'd0}, 32'h0bad_cafe);
    check_value("pready cycles", cycles, 1);
    check_value("pslverr", 32'(err), 32'd0);
    apb_read(make_paddr(size_w, {8'd140, 2'd0}), rdata, err, cycles);
    check_value("pready cycles", cycles, OUT_REG + 2);  // Wait states plus first access
    check_value("pslverr", 32'(err), 32'd0);
    check_value("prdata", rdata, 32'h0bad_cafe);
  endtask

  task automatic test_word_round_trip();
    logic [9:0]  baddr [10];
    logic [31:0] rdata;
    for (int i = 0; i < 10; i++) begin
      baddr[i] = {8'(i * 23 + 5), 2'b00};  // Ten distinct aligned words
      store(size_w, baddr[i], $random(seed));
    end
    for (int i = 0; i < 10; i++) begin
      load_check(size_w, baddr[i], rdata);
    end
  endtask

  task automatic test_byte_stores();
    logic [31:0] rdata;
    logic [31:0] mask;
    for (int k = 0; k < 4; k++) begin
      store(size_w, {8'(100 + k), 2'b00}, 32'h5aa5_c33c);
      store(size_b, {8'(100 + k), 2'(k)}, $random(seed));  // Lane k of word 100+k
    end
    for (int k = 0; k < 4; k++) begin
      load_check(size_w, {8'(100 + k), 2'b00}, rdata);
      mask = 32'hff << (8 * k);
      check_value("prdata other lanes", rdata & ~mask, 32'h5aa5_c33c & ~mask);
    end
  endtask

  task automatic test_sign_extension();
    store(size_b, {8'd120, 2'd0}, 32'h0000_0080);
    store(size_b, {8'd120, 2'd1}, 32'h0000_007f);
    store(size_h, {8'd120, 2'd2}, 32'h0000_8001);
    load_expect(size_b,  {8'd120, 2'd0}, 32'hffff_ff80);
    load_expect(size_bu, {8'd120, 2'd0}, 32'h0000_0080);
    load_expect(size_b,  {8'd120, 2'd1}, 32'h0000_007f);
    load_expect(size_bu, {8'd120, 2'd1}, 32'h0000_007f);
    load_expect(size_h,  {8'd120, 2'd2}, 32'hffff_8001);
    load_expect(size_hu, {8'd120, 2'd2}, 32'h0000_8001);
  endtask

  task automatic test_misaligned();
    store(size_w, {8'd130, 2'd0}, 32'hdead_beef);
    refused(1'b1, size_h, {8'd130, 2'd1});
    refused(1'b1, size_w, {8'd130, 2'd1});
    refused(1'b1, size_w, {8'd130, 2'd2});
    refused(1'b1, size_w, {8'd130, 2'd3});
    refused(1'b1, 3'b011, {8'd130, 2'd0});  // Not a legal width code
    refused(1'b0, size_hu, {8'd130, 2'd3});
    load_expect(size_w, {8'd130, 2'd0}, 32'hdead_beef);  // Word untouched
  endtask

  initial begin
    seed     = 33;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    rsta     = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (4) @(posedge clk);  // Four rising edges in reset
    @(negedge clk);
    rsta = 1'b0;
    test_timing();
    test_word_round_trip();
    test_byte_stores();
    test_sign_extension();
    test_misaligned();
    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/data_ram.sv
verilog/lsu_align.sv
verilog/apb_dmem_slave.sv
verilog/dmem_top.sv
tb/tb_clock.sv
tb/tb_dmem.sv

//--- Makefile
# Verilator build and run of the data memory testbench
TOP := tb_dmem

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
